// ==== frame_extrema_top.f ====
rtl/sample_pkg.sv
rtl/frame_pkg.sv
rtl/minmax_tree.sv
rtl/beat_sequencer.sv
rtl/extrema_accum.sv
rtl/frame_extrema_top.sv
verif/frame_extrema_checker.sv
verif/frame_extrema_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# compile and run the frame extrema testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
	--top-module frame_extrema_tb \
	-f frame_extrema_top.f \
	-o frame_extrema_sim

output=$(./obj_dir/frame_extrema_sim)
echo "$output"

if grep -qx "all tests passed" <<< "$output"; then
	exit 0
else
	exit 1
fi

// ==== verif/frame_extrema_tb.sv ====
`timescale 1ns/1ns

module frame_extrema_tb
	import sample_pkg::*, frame_pkg::*;
();

	localparam int NUM_LANES   = 8;
	localparam int FRAME_BEATS = 4;
	localparam int STAGES      = $clog2(NUM_LANES);
	localparam int MAX_GAP     = 3;
	localparam logic [31:0] SEED = 32'd92;

	localparam int MODE_RANDOM = 0;
	localparam int MODE_TIES   = 1;
	localparam int MODE_FLAT   = 2;
	localparam int MODE_MASKED = 3;
	localparam int MODE_EMPTY  = 4;

	// frame counts per phase, gapped phase long enough to wrap frame_id
	localparam int N_RANDOM = 8;
	localparam int N_TIES   = 10;
	localparam int N_FLAT   = 2;
	localparam int N_MASKED = 12;
	localparam int N_EMPTY  = 2;
	localparam int N_GAPPED = 130;
	localparam int N_FRAMES = N_RANDOM + N_TIES + N_FLAT + N_MASKED + N_EMPTY + 2 * N_GAPPED;

	localparam int TOTAL_BEATS     = N_FRAMES * FRAME_BEATS;
	localparam int GAP_CYCLES      = 2 * N_GAPPED * FRAME_BEATS * MAX_GAP;
	localparam int WATCHDOG_CYCLES = TOTAL_BEATS + GAP_CYCLES + 50;

	typedef struct packed {
		sample_t [NUM_LANES-1:0] samples;
		logic [NUM_LANES-1:0]    enable;
	} beat_t;

	logic                 clk = 1'b0;
	logic                 reset;
	logic                 in_strobe;
	sample_t              in_samples [NUM_LANES];
	logic [NUM_LANES-1:0] in_enable;
	logic                 result_strobe;
	frame_result_t        result;

	logic                 exp_valid;
	frame_result_t        exp_result;
	logic                 done;
	logic                 report_done;
	int                   error_count;

	logic [31:0] rng;
	int          frame_count;
	beat_t       frame_q [$];

	always #5 clk = ~clk;

	frame_extrema_top #(
		.NUM_LANES   (NUM_LANES),
		.FRAME_BEATS (FRAME_BEATS)
	) DUT (
		.clk           (clk),
		.reset         (reset),
		.in_strobe     (in_strobe),
		.in_samples    (in_samples),
		.in_enable     (in_enable),
		.result_strobe (result_strobe),
		.result        (result)
	);

	frame_extrema_checker #(
		.STAGES (STAGES)
	) u_checker (
		.clk           (clk),
		.reset         (reset),
		.result_strobe (result_strobe),
		.result        (result),
		.exp_valid     (exp_valid),
		.exp_result    (exp_result),
		.done          (done),
		.report_done   (report_done),
		.error_count   (error_count)
	);

	function automatic logic [31:0] lcg_step(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	// ----------------------------------------
	// reference model
	// ----------------------------------------

	// scan in beat then lane order, strict compare keeps the first occurrence
	function automatic frame_result_t ref_result(input beat_t beats [$], input int frame_num);
		frame_result_t r;
		sample_t       v;
		r = '0;
		r.frame_id = frame_id_t'(frame_num);
		for (int b = 0; b < beats.size(); b++) begin
			for (int l = 0; l < NUM_LANES; l++) begin
				if (beats[b].enable[l]) begin
					v = beats[b].samples[l];
					if (!r.found || $signed(v) > $signed(r.max_value)) begin
						r.max_value = v;
						r.max_beat  = beat_idx_t'(b);
						r.max_lane  = lane_idx_t'(l);
					end
					if (!r.found || $signed(v) < $signed(r.min_value)) begin
						r.min_value = v;
						r.min_beat  = beat_idx_t'(b);
						r.min_lane  = lane_idx_t'(l);
					end
					r.found = 1'b1;
				end
			end
		end
		return r;
	endfunction

	// ----------------------------------------
	// stimulus
	// ----------------------------------------

	task automatic make_beat(input int mode, output beat_t b);
		for (int l = 0; l < NUM_LANES; l++) begin
			rng = lcg_step(rng);
			case (mode)
				// narrow range, lots of equal extremes
				MODE_TIES: b.samples[l] = sample_t'(int'(rng[31:16] % 16'd3) - 1);
				MODE_FLAT: b.samples[l] = sample_t'(7);
				default:   b.samples[l] = sample_t'(rng[31:16]);
			endcase
		end
		rng = lcg_step(rng);
		case (mode)
			MODE_MASKED: b.enable = (rng[31:30] == 2'b00) ? '0 : NUM_LANES'(rng >> 16);
			MODE_EMPTY:  b.enable = '0;
			default:     b.enable = '1;
		endcase
	endtask

	task automatic drive_beat(input beat_t b, input logic is_last, input frame_result_t expected);
		@(posedge clk);
		in_strobe <= 1'b1;
		for (int l = 0; l < NUM_LANES; l++) begin
			in_samples[l] <= b.samples[l];
		end
		in_enable  <= b.enable;
		exp_valid  <= is_last;
		exp_result <= expected;
	endtask

	task automatic idle(input int cycles);
		repeat (cycles) begin
			@(posedge clk);
			in_strobe <= 1'b0;
			exp_valid <= 1'b0;
		end
	endtask

	task automatic run_frames(input int mode, input int count, input int max_gap);
		beat_t         b;
		frame_result_t expected;
		int            gap;
		for (int f = 0; f < count; f++) begin
			frame_q.delete();
			expected = '0;
			for (int i = 0; i < FRAME_BEATS; i++) begin
				make_beat(mode, b);
				frame_q.push_back(b);
				if (i == FRAME_BEATS - 1)
					expected = ref_result(frame_q, frame_count);
				drive_beat(b, i == FRAME_BEATS - 1, expected);
				gap = 0;
				if (max_gap > 0) begin
					rng = lcg_step(rng);
					gap = int'(rng[31:16]) % (max_gap + 1);
				end
				idle(gap);
			end
			frame_count++;
		end
	endtask

	initial begin
		reset = 1'b1;
		in_strobe = 1'b0;
		in_enable = '0;
		for (int l = 0; l < NUM_LANES; l++) begin
			in_samples[l] = '0;
		end
		exp_valid = 1'b0;
		exp_result = '0;
		done = 1'b0;
		rng = SEED;
		frame_count = 0;

		repeat (16) @(posedge clk);
		reset <= 1'b0;
		idle(4);

		run_frames(MODE_RANDOM, N_RANDOM, 0);
		run_frames(MODE_TIES, N_TIES, 0);
		run_frames(MODE_FLAT, N_FLAT, 0);
		run_frames(MODE_MASKED, N_MASKED, 0);
		run_frames(MODE_EMPTY, N_EMPTY, 0);
		run_frames(MODE_RANDOM, N_GAPPED, MAX_GAP);
		run_frames(MODE_MASKED, N_GAPPED, MAX_GAP);

		// drain the pipeline
		idle(STAGES + 4);
		@(posedge clk);
		done <= 1'b1;
		wait (report_done);
		if (error_count == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

	initial begin
		#(WATCHDOG_CYCLES * 10);
		$display("watchdog expired after %0d cycles before the run completed", WATCHDOG_CYCLES);
		$display("tests failed");
		$finish;
	end

endmodule

// ==== verif/frame_extrema_checker.sv ====
`timescale 1ns/1ns

module frame_extrema_checker
	import sample_pkg::*, frame_pkg::*;
#(
	parameter int STAGES = 3
) (
	input  logic          clk,
	input  logic          reset,
	input  logic          result_strobe,
	input  frame_result_t result,
	input  logic          exp_valid,
	input  frame_result_t exp_result,
	input  logic          done,
	output logic          report_done,
	output int            error_count
);

	// expected results and the cycle each one is due
	frame_result_t exp_q [$];
	int unsigned   due_q [$];

	int unsigned cycle_count = 0;
	int checked = 0;
	int value_errors = 0;
	int latency_errors = 0;
	int unexpected_errors = 0;
	int missing_errors = 0;

	assign error_count = value_errors + latency_errors + unexpected_errors + missing_errors;

	task automatic compare_field(input string name, input int expected, input int actual);
		if (expected != actual) begin
			value_errors++;
			$display("CHECK FAILED at %0t ns: %s expected %0d actual %0d",
				$time, name, expected, actual);
		end
	endtask

	task automatic compare_result(input frame_result_t expected, input frame_result_t actual);
		compare_field("result.frame_id", int'(expected.frame_id), int'(actual.frame_id));
		compare_field("result.found", int'(expected.found), int'(actual.found));
		// locations mean nothing when no lane was enabled
		if (expected.found) begin
			compare_field("result.max_value", int'($signed(expected.max_value)),
				int'($signed(actual.max_value)));
			compare_field("result.max_beat", int'(expected.max_beat), int'(actual.max_beat));
			compare_field("result.max_lane", int'(expected.max_lane), int'(actual.max_lane));
			compare_field("result.min_value", int'($signed(expected.min_value)),
				int'($signed(actual.min_value)));
			compare_field("result.min_beat", int'(expected.min_beat), int'(actual.min_beat));
			compare_field("result.min_lane", int'(expected.min_lane), int'(actual.min_lane));
		end
	endtask

	// ----------------------------------------
	// result watch
	// ----------------------------------------

	always @(posedge clk) begin
		frame_result_t expected;
		int unsigned   due;
		cycle_count <= cycle_count + 1;
		if (reset) begin
			report_done <= 1'b0;
			if (result_strobe) begin
				unexpected_errors++;
				$display("result strobe seen during reset at %0t ns", $time);
			end
		end else begin
			// last beat enters in this cycle
			if (exp_valid) begin
				exp_q.push_back(exp_result);
				due_q.push_back(cycle_count + STAGES + 2);
			end
			if (result_strobe) begin
				if (exp_q.size() == 0) begin
					unexpected_errors++;
					$display("unexpected result at %0t ns, no frame was pending", $time);
				end else begin
					expected = exp_q.pop_front();
					due = due_q.pop_front();
					checked++;
					compare_result(expected, result);
					if (cycle_count != due) begin
						latency_errors++;
						$display("result for frame %0d came at cycle %0d instead of cycle %0d",
							expected.frame_id, cycle_count, due);
					end
				end
			end
			if (done && !report_done) begin
				if (exp_q.size() != 0) begin
					missing_errors += exp_q.size();
					$display("%0d expected results never arrived", exp_q.size());
				end
				$display("frames %0d, value errors %0d, latency errors %0d, unexpected %0d, missing %0d",
					checked, value_errors, latency_errors, unexpected_errors, missing_errors);
				report_done <= 1'b1;
			end
		end
	end

endmodule

// ==== rtl/frame_extrema_top.sv ====
`timescale 1ns/1ns

module frame_extrema_top
	import sample_pkg::*, frame_pkg::*;
#(
	parameter int NUM_LANES   = 8,
	parameter int FRAME_BEATS = 4
) (
	input  logic                 clk,
	input  logic                 reset,

	input  logic                 in_strobe,
	input  sample_t              in_samples [NUM_LANES],
	input  logic [NUM_LANES-1:0] in_enable,

	output logic                 result_strobe,
	output frame_result_t        result
);

	logic                 beat_strobe;
	sample_t              beat_samples [NUM_LANES];
	logic [NUM_LANES-1:0] beat_enable;
	beat_tag_t            beat_tag;

	logic                 pick_strobe;
	beat_tag_t            pick_tag;
	pick_t                max_pick;
	pick_t                min_pick;

	beat_sequencer #(
		.NUM_LANES   (NUM_LANES),
		.FRAME_BEATS (FRAME_BEATS)
	) u_sequencer (
		.clk          (clk),
		.reset        (reset),
		.in_strobe    (in_strobe),
		.in_samples   (in_samples),
		.in_enable    (in_enable),
		.beat_strobe  (beat_strobe),
		.beat_samples (beat_samples),
		.beat_enable  (beat_enable),
		.beat_tag     (beat_tag)
	);

	// ----------------------------------------
	// max and min trees, same latency
	// ----------------------------------------

	minmax_tree #(
		.NUM_LANES (NUM_LANES),
		.PICK_MIN  (1'b0)
	) u_max_tree (
		.clk         (clk),
		.reset       (reset),
		.in_strobe   (beat_strobe),
		.in_samples  (beat_samples),
		.in_enable   (beat_enable),
		.in_tag      (beat_tag),
		.pick_strobe (pick_strobe),
		.pick        (max_pick),
		.pick_tag    (pick_tag)
	);

	// strobe and tag taken from the max tree
	minmax_tree #(
		.NUM_LANES (NUM_LANES),
		.PICK_MIN  (1'b1)
	) u_min_tree (
		.clk         (clk),
		.reset       (reset),
		.in_strobe   (beat_strobe),
		.in_samples  (beat_samples),
		.in_enable   (beat_enable),
		.in_tag      (beat_tag),
		.pick_strobe (),
		.pick        (min_pick),
		.pick_tag    ()
	);

	extrema_accum u_accum (
		.clk           (clk),
		.reset         (reset),
		.pick_strobe   (pick_strobe),
		.max_pick      (max_pick),
		.min_pick      (min_pick),
		.pick_tag      (pick_tag),
		.result_strobe (result_strobe),
		.result        (result)
	);

endmodule

// ==== rtl/extrema_accum.sv ====
`timescale 1ns/1ns

module extrema_accum
	import sample_pkg::*, frame_pkg::*;
(
	input  logic          clk,
	input  logic          reset,

	input  logic          pick_strobe,
	input  pick_t         max_pick,
	input  pick_t         min_pick,
	input  beat_tag_t     pick_tag,

	output logic          result_strobe,
	output frame_result_t result
);

	// running state of the current frame
	frame_result_t acc;
	frame_result_t acc_next;

	logic take_max;
	logic take_min;

	// ----------------------------------------
	// merge one beat into the running state
	// ----------------------------------------

	// strictly better only, so ties stay with the earlier beat
	assign take_max = pick_tag.first
		|| (max_pick.found
			&& (!acc.found || $signed(max_pick.value) > $signed(acc.max_value)));
	assign take_min = pick_tag.first
		|| (min_pick.found
			&& (!acc.found || $signed(min_pick.value) < $signed(acc.min_value)));

	always_comb begin
		acc_next = acc;
		acc_next.frame_id = pick_tag.frame_id;
		if (take_max) begin
			acc_next.max_value = max_pick.value;
			acc_next.max_beat  = pick_tag.beat_idx;
			acc_next.max_lane  = max_pick.lane;
		end
		if (take_min) begin
			acc_next.min_value = min_pick.value;
			acc_next.min_beat  = pick_tag.beat_idx;
			acc_next.min_lane  = min_pick.lane;
		end
		if (pick_tag.first)
			acc_next.found = max_pick.found | min_pick.found;
		else
			acc_next.found = acc.found | max_pick.found | min_pick.found;
	end

	// ----------------------------------------
	// state and result registers
	// ----------------------------------------

	always_ff @(posedge clk) begin
		if (pick_strobe) begin
			acc <= acc_next;
		end
	end

	always_ff @(posedge clk) begin
		if (pick_strobe && pick_tag.last) begin
			result <= acc_next;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			result_strobe <= 1'b0;
		end else begin
			result_strobe <= pick_strobe & pick_tag.last;
		end
	end

endmodule

// ==== rtl/beat_sequencer.sv ====
`timescale 1ns/1ns

module beat_sequencer
	import sample_pkg::*, frame_pkg::*;
#(
	parameter int NUM_LANES   = 8,
	parameter int FRAME_BEATS = 4
) (
	input  logic                 clk,
	input  logic                 reset,

	input  logic                 in_strobe,
	input  sample_t              in_samples [NUM_LANES],
	input  logic [NUM_LANES-1:0] in_enable,

	output logic                 beat_strobe,
	output sample_t              beat_samples [NUM_LANES],
	output logic [NUM_LANES-1:0] beat_enable,
	output beat_tag_t            beat_tag
);

	localparam beat_idx_t LAST_BEAT = BEAT_IDX_WIDTH'(FRAME_BEATS - 1);

	beat_idx_t beat_count;
	frame_id_t frame_id;
	logic      last_beat;

	assign last_beat = (beat_count == LAST_BEAT);

	// frame boundaries all come from here
	always_ff @(posedge clk) begin
		if (reset) begin
			beat_strobe <= 1'b0;
			beat_count  <= '0;
			frame_id    <= '0;
		end else begin
			beat_strobe <= in_strobe;
			if (in_strobe) begin
				if (last_beat) begin
					beat_count <= '0;
					frame_id   <= frame_id + 1'b1;
				end else begin
					beat_count <= beat_count + 1'b1;
				end
			end
		end
	end

	// beat payload and its tag
	always_ff @(posedge clk) begin
		if (in_strobe) begin
			beat_samples      <= in_samples;
			beat_enable       <= in_enable;
			beat_tag.frame_id <= frame_id;
			beat_tag.beat_idx <= beat_count;
			beat_tag.first    <= (beat_count == '0);
			beat_tag.last     <= last_beat;
		end
	end

endmodule

// ==== rtl/minmax_tree.sv ====
`timescale 1ns/1ns

module minmax_tree
	import sample_pkg::*, frame_pkg::*;
#(
	parameter int NUM_LANES = 8,
	parameter bit PICK_MIN  = 0
) (
	input  logic            clk,
	input  logic            reset,

	input  logic            in_strobe,
	input  sample_t         in_samples [NUM_LANES],
	input  logic [NUM_LANES-1:0] in_enable,
	input  beat_tag_t       in_tag,

	output logic            pick_strobe,
	output pick_t           pick,
	output beat_tag_t       pick_tag
);

	localparam int STAGES = $clog2(NUM_LANES);
	localparam int HALF   = NUM_LANES / 2;

	// ----------------------------------------
	// node compare
	// ----------------------------------------

	// right side wins only when strictly better, so ties keep the lower lane
	function automatic pick_t pick_of(input pick_t a, input pick_t b);
		logic  take_b;
		pick_t r;
		if (a.found && b.found) begin
			if (PICK_MIN)
				take_b = $signed(b.value) < $signed(a.value);
			else
				take_b = $signed(b.value) > $signed(a.value);
		end else begin
			// enabled beats disabled, neither enabled keeps left
			take_b = b.found;
		end
		r = take_b ? b : a;
		r.found = a.found | b.found;
		return r;
	endfunction

	// ----------------------------------------
	// leaves
	// ----------------------------------------

	pick_t leaf [NUM_LANES];

	for (genvar l = 0; l < NUM_LANES; l++) begin : g_leaf
		assign leaf[l].value = in_samples[l];
		assign leaf[l].lane  = LANE_IDX_WIDTH'(l);
		assign leaf[l].found = in_enable[l];
	end

	// ----------------------------------------
	// reduction stages
	// ----------------------------------------

	// stage s holds NUM_LANES >> (s+1) live nodes
	pick_t stage_q [STAGES][HALF];

	for (genvar s = 0; s < STAGES; s++) begin : g_stage
		for (genvar n = 0; n < (NUM_LANES >> (s + 1)); n++) begin : g_node
			if (s == 0) begin : g_first
				always_ff @(posedge clk) begin
					stage_q[0][n] <= pick_of(leaf[2*n], leaf[2*n+1]);
				end
			end else begin : g_next
				always_ff @(posedge clk) begin
					stage_q[s][n] <= pick_of(stage_q[s-1][2*n], stage_q[s-1][2*n+1]);
				end
			end
		end
	end

	// ----------------------------------------
	// tag and strobe alongside the tree
	// ----------------------------------------

	beat_tag_t         tag_q [STAGES];
	logic [STAGES-1:0] strobe_q;

	always_ff @(posedge clk) begin
		tag_q[0] <= in_tag;
		for (int i = 1; i < STAGES; i++) begin
			tag_q[i] <= tag_q[i-1];
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			strobe_q <= '0;
		end else begin
			strobe_q <= STAGES'({strobe_q, in_strobe});
		end
	end

	assign pick_strobe = strobe_q[STAGES-1];
	assign pick        = stage_q[STAGES-1][0];
	assign pick_tag    = tag_q[STAGES-1];

endmodule

// ==== rtl/frame_pkg.sv ====
package frame_pkg;

	localparam int BEAT_IDX_WIDTH = 8;

	// frame number wraps
	localparam int FRAME_ID_WIDTH = 8;

	typedef logic [BEAT_IDX_WIDTH-1:0] beat_idx_t;
	typedef logic [FRAME_ID_WIDTH-1:0] frame_id_t;

	// tag carried alongside each beat
	typedef struct packed {
		frame_id_t frame_id;
		beat_idx_t beat_idx;
		logic      first;
		logic      last;
	} beat_tag_t;

	// one per frame, max and min with location
	typedef struct packed {
		frame_id_t            frame_id;
		sample_pkg::sample_t   max_value;
		beat_idx_t            max_beat;
		sample_pkg::lane_idx_t max_lane;
		sample_pkg::sample_t   min_value;
		beat_idx_t            min_beat;
		sample_pkg::lane_idx_t min_lane;
		logic                 found;
	} frame_result_t;

endpackage

// ==== rtl/sample_pkg.sv ====
package sample_pkg;

	// ----------------------------------------
	// sample format
	// ----------------------------------------

	localparam int SAMPLE_WIDTH = 16;

	typedef logic signed [SAMPLE_WIDTH-1:0] sample_t;

	// ----------------------------------------
	// lane indexing
	// ----------------------------------------

	// widest line array supported
	localparam int MAX_LANES = 64;
	localparam int LANE_IDX_WIDTH = $clog2(MAX_LANES);

	typedef logic [LANE_IDX_WIDTH-1:0] lane_idx_t;

	// ----------------------------------------
	// per-beat winner
	// ----------------------------------------

	// found is low when no lane of the beat was enabled
	typedef struct packed {
		sample_t   value;
		lane_idx_t lane;
		logic      found;
	} pick_t;

endpackage
